// ==== build.f ====
source/trig_pkg.sv
source/input_sync.sv
source/threshold_detector.sv
source/sample_decimator.sv
source/acq_controller.sv
source/triggerer_top.sv
verif/triggerer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the triggerer testbench with Verilator, runs it and checks the log for the pass message.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
   --top-module triggerer_tb \
   -f build.f \
   -o triggerer_sim \
   && ./obj_dir/triggerer_sim 2>&1 | tee sim.log \
   || { echo "verilator build or simulation run failed"; exit 1; }

grep -q "^Simulation finished: PASS$" sim.log \
   && echo "log check: run passed" \
   || { echo "log check: run failed"; exit 1; }

// ==== source/acq_controller.sv ====
// stage 3, acquisition fsm with trigger decisions, length counters and the done_req/done_ack readout
module acq_controller #(
   parameter int ADDR_W = 10 // ram address width
) (
   input  logic                          clklvds,
   input  logic                          arst_n,
   input  logic [trig_pkg::LEN_W-1:0]    pre_len_s,   // write periods before trigger
   input  logic [trig_pkg::LEN_W-1:0]    post_len_s,  // write periods after trigger
   input  logic [7:0]                    trig_type_s, // host trigger type code
   input  logic [trig_pkg::TOT_W-1:0]    tot_s,       // time over threshold
   input  logic                          live_s,      // host allows arming
   input  logic                          ext_level,   // synced back panel level
   input  logic                          ext_rise,    // first cycle of ext_level
   input  logic                          any_below,   // word crossed lower threshold
   input  logic                          any_above,   // word crossed upper threshold
   input  logic                          write_tick,  // decimation period ends
   input  logic [ADDR_W-1:0]             wr_addr,     // current ram address
   output logic                          record_en,   // decimator runs
   output logic                          trig_out,    // high through ST_POST
   output logic [ADDR_W-1:0]             trig_addr,   // ram address of the trigger
   output logic [31:0]                   event_count, // completed events
   output logic                          done_req,    // buffer ready for readout
   input  logic                          done_ack,    // host has read out
   output trig_pkg::acq_state_e          acq_state
);

   import trig_pkg::*;

   trig_type_e        act_type;     // type latched when leaving idle
   logic [LEN_W-1:0]  len_cnt;      // pre and post write periods
   logic [TOT_W-1:0]  tot_cnt;      // time over threshold, write periods or cycles
   logic              ext_seen;     // rising edge seen in ST_EXT
   logic              ack_seen;     // handshake past phase 2
   logic              type_changed; // host rewrote the type while armed
   logic              first_hit;    // first step of the threshold edge
   logic              hold_hit;     // second step, must hold for tot
   logic              ext_ok;       // external input high after its edge
   logic              post_last;    // last post period ends this cycle
   logic              fire_now;     // trigger condition seen this cycle

   assign record_en    = (acq_state != ST_IDLE) && (acq_state != ST_HOLD);
   assign type_changed = (trig_type_s != act_type);
   assign first_hit    = (act_type == TRIG_RISING) ? any_below : any_above; // falling is mirrored
   assign hold_hit     = (act_type == TRIG_RISING) ? any_above : any_below;
   assign ext_ok       = (ext_seen | ext_rise) & ext_level;
   assign post_last    = (len_cnt >= post_len_s) ||
                         (write_tick && (len_cnt == post_len_s - 1'b1));

   always_comb begin
      case (acq_state)
         ST_FIRE: fire_now = !type_changed && hold_hit && (tot_cnt >= tot_s);
         ST_EXT:  fire_now = !type_changed && ext_ok && (tot_cnt >= tot_s);
         ST_AUTO: fire_now = 1'b1; // unconditional
         default: fire_now = 1'b0;
      endcase
   end

   always_ff @(posedge clklvds or negedge arst_n) begin
      if (!arst_n) begin
         acq_state   <= ST_IDLE;
         act_type    <= TRIG_OFF;
         len_cnt     <= '0;
         tot_cnt     <= '0;
         ext_seen    <= 1'b0;
         ack_seen    <= 1'b0;
         trig_out    <= 1'b0;
         trig_addr   <= '0;
         event_count <= '0;
         done_req    <= 1'b0;
      end else begin
         case (acq_state)
            ST_IDLE: begin
               len_cnt  <= '0;
               tot_cnt  <= '0;
               ext_seen <= 1'b0;
               trig_out <= 1'b0;
               if (trig_type_s != TRIG_OFF && live_s) begin
                  act_type  <= trig_type_e'(trig_type_s); // compared against host from here on
                  acq_state <= ST_PRE;
               end
            end
            ST_PRE: begin
               if (type_changed) acq_state <= ST_IDLE;
               else if (len_cnt < pre_len_s) begin
                  if (write_tick) len_cnt <= len_cnt + 1'b1;
               end else begin
                  len_cnt <= '0; // reused for the post length
                  case (act_type)
                     TRIG_RISING, TRIG_FALLING: acq_state <= ST_ARM;
                     TRIG_AUTO:                 acq_state <= ST_AUTO;
                     TRIG_EXT:                  acq_state <= ST_EXT;
                     default:                   acq_state <= ST_IDLE;
                  endcase
               end
            end
            ST_ARM: begin
               if (type_changed) acq_state <= ST_IDLE;
               else if (first_hit) begin
                  tot_cnt   <= '0;
                  acq_state <= ST_FIRE;
               end
            end
            ST_FIRE: begin
               if (type_changed) acq_state <= ST_IDLE;
               else if (!hold_hit) tot_cnt <= '0; // run broken, start over
               else if (write_tick) tot_cnt <= tot_cnt + 1'b1;
            end
            ST_EXT: begin
               if (type_changed) acq_state <= ST_IDLE;
               else begin
                  if (ext_rise) ext_seen <= 1'b1;
                  if (ext_ok) tot_cnt <= tot_cnt + 1'b1; // counts clock cycles here
                  else tot_cnt <= '0;
               end
            end
            ST_POST: begin
               if (post_last) begin
                  len_cnt     <= '0;
                  trig_out    <= 1'b0;
                  event_count <= event_count + 1'b1;
                  acq_state   <= ST_HOLD;
               end else if (write_tick) len_cnt <= len_cnt + 1'b1;
            end
            ST_HOLD: begin
               if (!ack_seen) begin
                  if (done_req && done_ack) begin
                     done_req <= 1'b0; // phase 3
                     ack_seen <= 1'b1;
                  end else if (!done_ack) done_req <= 1'b1; // phase 1, after the last write
               end else if (!done_ack) begin
                  ack_seen  <= 1'b0; // host released ack, rearm
                  acq_state <= ST_IDLE;
               end
            end
            default: acq_state <= ST_IDLE;
         endcase
         // common firing path overrides the per state updates
         if (fire_now) begin
            trig_addr <= wr_addr - ADDR_W'(tot_s); // back to where the run began
            trig_out  <= 1'b1;
            len_cnt   <= '0;
            acq_state <= ST_POST;
         end
      end
   end

endmodule

// ==== source/input_sync.sv ====
// stage 1, registers samples and host configuration into clklvds and edge detects the external trigger
module input_sync #(
   parameter int SAMPLES_PER_CLK = 4 // adc samples per clklvds cycle
) (
   input  logic                        clklvds,
   input  logic                        arst_n,
   input  trig_pkg::sample_t           samples [SAMPLES_PER_CLK], // raw adc word
   input  trig_pkg::sample_t           lower,        // lower threshold
   input  trig_pkg::sample_t           upper,        // upper threshold
   input  logic [trig_pkg::LEN_W-1:0]  pre_len,      // write periods before trigger
   input  logic [trig_pkg::LEN_W-1:0]  post_len,     // write periods after trigger
   input  logic [7:0]                  trig_type,    // host trigger type code
   input  logic [trig_pkg::TOT_W-1:0]  tot,          // time over threshold
   input  logic [trig_pkg::DS_W-1:0]   downsample,   // downsample exponent
   input  logic [trig_pkg::MERGE_W-1:0] merge,       // merging count
   input  logic                        trigger_live, // host allows arming
   input  logic                        ext_trig,     // back panel input, async
   output trig_pkg::sample_t           samples_s [SAMPLES_PER_CLK],
   output trig_pkg::sample_t           lower_s,
   output trig_pkg::sample_t           upper_s,
   output logic [trig_pkg::LEN_W-1:0]  pre_len_s,
   output logic [trig_pkg::LEN_W-1:0]  post_len_s,
   output logic [7:0]                  trig_type_s,
   output logic [trig_pkg::TOT_W-1:0]  tot_s,
   output logic [trig_pkg::DS_W-1:0]   downsample_s,
   output logic [trig_pkg::MERGE_W-1:0] merge_s,
   output logic                        live_s,
   output logic                        ext_level,    // ext_trig after two flops
   output logic                        ext_rise      // high on the first cycle of ext_level
);

   logic ext_meta; // first flop of the back panel input

   always_ff @(posedge clklvds) begin
      samples_s <= samples; // sample payload, one stage
   end

   always_ff @(posedge clklvds or negedge arst_n) begin
      if (!arst_n) begin
         lower_s      <= '0;
         upper_s      <= '0;
         pre_len_s    <= '0;
         post_len_s   <= '0;
         trig_type_s  <= '0; // off until the host writes a type
         tot_s        <= '0;
         downsample_s <= '0;
         merge_s      <= '0;
         live_s       <= 1'b0;
         ext_meta     <= 1'b0;
         ext_level    <= 1'b0;
         ext_rise     <= 1'b0;
      end else begin
         lower_s      <= lower;
         upper_s      <= upper;
         pre_len_s    <= pre_len;
         post_len_s   <= post_len;
         trig_type_s  <= trig_type;
         tot_s        <= tot;
         downsample_s <= downsample;
         merge_s      <= merge;
         live_s       <= trigger_live;
         ext_meta     <= ext_trig;              // may go metastable
         ext_level    <= ext_meta;              // settled level
         ext_rise     <= ext_meta & ~ext_level; // lines up with the first high ext_level
      end
   end

endmodule

// ==== source/sample_decimator.sv ====
// write-rate stage, downsamples and merges while recording and drives the ram write strobe and address
module sample_decimator #(
   parameter int ADDR_W = 10 // ram address width, address wraps at 2**ADDR_W
) (
   input  logic                          clklvds,
   input  logic                          arst_n,
   input  logic                          record_en,    // fsm is recording
   input  logic [trig_pkg::DS_W-1:0]     downsample_s, // period exponent
   input  logic [trig_pkg::MERGE_W-1:0]  merge_s,      // merging count
   output logic                          write_tick,   // last cycle of a decimation period
   output logic                          ram_wr,       // one cycle after write_tick
   output logic [ADDR_W-1:0]             wr_addr       // current write address
);

   import trig_pkg::*;

   localparam int DS_CNT_W = 2**DS_W; // one bit per possible exponent

   logic [DS_CNT_W-1:0] ds_cnt;    // runs 1 .. 2**downsample_s
   logic [MERGE_W-1:0]  merge_cnt; // runs 1 .. merge_s
   logic                ds_done;   // downsample period expires this cycle
   logic                merge_done;

   assign ds_done    = ds_cnt[downsample_s];        // single bit set at the period end
   assign merge_done = (merge_cnt >= merge_s);      // merge_s of 0 behaves as 1
   assign write_tick = record_en & ds_done & merge_done;

   always_ff @(posedge clklvds or negedge arst_n) begin
      if (!arst_n) begin
         ds_cnt    <= DS_CNT_W'(1);
         merge_cnt <= MERGE_W'(1);
         ram_wr    <= 1'b0;
         wr_addr   <= '0;
      end else if (!record_en) begin
         ds_cnt    <= DS_CNT_W'(1); // reload, no writes outside recording
         merge_cnt <= MERGE_W'(1);
         ram_wr    <= 1'b0;
      end else if (ds_done) begin
         ds_cnt <= DS_CNT_W'(1);
         if (merge_done) begin
            merge_cnt <= MERGE_W'(1);
            wr_addr   <= wr_addr + 1'b1; // wraps in ram
            ram_wr    <= 1'b1;
         end else begin
            merge_cnt <= merge_cnt + 1'b1;
            ram_wr    <= 1'b0;
         end
      end else begin
         ds_cnt <= ds_cnt + 1'b1;
         ram_wr <= 1'b0;
      end
   end

endmodule

// ==== source/threshold_detector.sv ====
// stage 2, compares every sample of a clock word against both thresholds and registers two flags
module threshold_detector #(
   parameter int SAMPLES_PER_CLK = 4 // adc samples per clklvds cycle
) (
   input  logic              clklvds,
   input  logic              arst_n,
   input  trig_pkg::sample_t samples_s [SAMPLES_PER_CLK], // registered adc word
   input  trig_pkg::sample_t lower_s,   // signed lower threshold
   input  trig_pkg::sample_t upper_s,   // signed upper threshold
   output logic              any_below, // some sample under lower_s
   output logic              any_above  // some sample over upper_s
);

   logic [SAMPLES_PER_CLK-1:0] below_vec; // per sample compare against lower
   logic [SAMPLES_PER_CLK-1:0] above_vec; // per sample compare against upper

   // both sides are signed, so compares are signed
   always_comb begin
      for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
         below_vec[i] = (samples_s[i] < lower_s);
         above_vec[i] = (samples_s[i] > upper_s);
      end
   end

   // reduce the word, two cycles from the sample pins
   always_ff @(posedge clklvds or negedge arst_n) begin
      if (!arst_n) begin
         any_below <= 1'b0;
         any_above <= 1'b0;
      end else begin
         any_below <= |below_vec; // any sample is enough
         any_above <= |above_vec;
      end
   end

endmodule

// ==== source/trig_pkg.sv ====
// shared widths, sample type and enums for the trigger and sample-write controller, import where needed
package trig_pkg;

   localparam int SAMPLE_W = 12; // adc sample width
   localparam int LEN_W    = 16; // pre and post trigger length counters
   localparam int TOT_W    = 8;  // time over threshold value and counter
   localparam int MERGE_W  = 8;  // merging count
   localparam int DS_W     = 5;  // downsample exponent, period is 2**downsample

   // one signed adc sample
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // trigger type codes as written by the host
   typedef enum logic [7:0] {
      TRIG_OFF     = 8'd0, // conditional triggering disabled
      TRIG_RISING  = 8'd1, // threshold, rising edge
      TRIG_FALLING = 8'd2, // threshold, falling edge
      TRIG_AUTO    = 8'd4, // capture unconditionally
      TRIG_EXT     = 8'd5  // back panel input
   } trig_type_e;

   // acquisition fsm states
   typedef enum logic [3:0] {
      ST_IDLE = 4'd0, // waiting for a trigger type and live
      ST_PRE  = 4'd1, // recording the pre trigger length
      ST_ARM  = 4'd2, // threshold, first step of the edge
      ST_FIRE = 4'd3, // threshold, second step with time over threshold
      ST_EXT  = 4'd4, // waiting on the back panel input
      ST_AUTO = 4'd5, // fires on the next edge
      ST_POST = 4'd6, // recording the post trigger length
      ST_HOLD = 4'd7  // buffer full, waiting for readout
   } acq_state_e;

endpackage

// ==== source/triggerer_top.sv ====
// top level of the trigger and sample-write controller, chains the stages and sets the parameters
module triggerer_top #(
   parameter int SAMPLES_PER_CLK = 4, // adc samples per clklvds cycle
   parameter int ADDR_W          = 10 // ram address width
) (
   input  logic                          clklvds,
   input  logic                          arst_n,
   input  trig_pkg::sample_t             samples [SAMPLES_PER_CLK],
   input  trig_pkg::sample_t             lower,
   input  trig_pkg::sample_t             upper,
   input  logic [trig_pkg::LEN_W-1:0]    pre_len,
   input  logic [trig_pkg::LEN_W-1:0]    post_len,
   input  logic [7:0]                    trig_type,
   input  logic [trig_pkg::TOT_W-1:0]    tot,
   input  logic [trig_pkg::DS_W-1:0]     downsample,
   input  logic [trig_pkg::MERGE_W-1:0]  merge,
   input  logic                          trigger_live,
   input  logic                          ext_trig,
   input  logic                          done_ack,
   output logic                          ram_wr,
   output logic [ADDR_W-1:0]             wr_addr,
   output logic                          trig_out,
   output logic [ADDR_W-1:0]             trig_addr,
   output logic [31:0]                   event_count,
   output logic                          done_req,
   output trig_pkg::acq_state_e          acq_state
);

   import trig_pkg::*;

   sample_t            samples_s [SAMPLES_PER_CLK]; // stage 1 word
   sample_t            lower_s, upper_s;
   logic [LEN_W-1:0]   pre_len_s, post_len_s;
   logic [7:0]         trig_type_s;
   logic [TOT_W-1:0]   tot_s;
   logic [DS_W-1:0]    downsample_s;
   logic [MERGE_W-1:0] merge_s;
   logic               live_s, ext_level, ext_rise;
   logic               any_below, any_above; // stage 2 flags
   logic               record_en, write_tick;

   input_sync #(.SAMPLES_PER_CLK(SAMPLES_PER_CLK)) u_sync (
      .clklvds, .arst_n, .samples, .lower, .upper, .pre_len, .post_len, .trig_type,
      .tot, .downsample, .merge, .trigger_live, .ext_trig, .samples_s, .lower_s,
      .upper_s, .pre_len_s, .post_len_s, .trig_type_s, .tot_s, .downsample_s,
      .merge_s, .live_s, .ext_level, .ext_rise
   );

   threshold_detector #(.SAMPLES_PER_CLK(SAMPLES_PER_CLK)) u_thresh (
      .clklvds, .arst_n, .samples_s, .lower_s, .upper_s, .any_below, .any_above
   );

   sample_decimator #(.ADDR_W(ADDR_W)) u_decim (
      .clklvds, .arst_n, .record_en, .downsample_s, .merge_s, .write_tick, .ram_wr,
      .wr_addr
   );

   acq_controller #(.ADDR_W(ADDR_W)) u_ctrl (
      .clklvds, .arst_n, .pre_len_s, .post_len_s, .trig_type_s, .tot_s, .live_s,
      .ext_level, .ext_rise, .any_below, .any_above, .write_tick, .wr_addr, .record_en,
      .trig_out, .trig_addr, .event_count, .done_req, .done_ack, .acq_state
   );

endmodule

// ==== verif/triggerer_tb.sv ====
// testbench for triggerer_top, reads verif/triggerer_testdata.txt and checks writes, triggers and readout
module triggerer_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import trig_pkg::*;

   localparam int SPC    = 4;
   localparam int ADDR_W = 10;
   localparam int CLK_NS = 40;
   localparam int F_TYPE = 0, F_LOW = 1, F_UP = 2, F_PRE = 3, F_POST = 4, F_TOT = 5;
   localparam int F_DS = 6, F_MRG = 7, F_PAT = 8, F_EXT = 9, F_EXP = 10;
   localparam int QUIET = 0, BELOW = 1, ABOVE = 2; // word modes

   logic clklvds, arst_n, trigger_live, ext_trig, done_ack;
   sample_t samples [SPC];
   sample_t lower, upper;
   logic [LEN_W-1:0] pre_len, post_len;
   logic [7:0] trig_type;
   logic [TOT_W-1:0] tot;
   logic [DS_W-1:0] downsample;
   logic [MERGE_W-1:0] merge;
   logic ram_wr, trig_out, done_req;
   logic [ADDR_W-1:0] wr_addr, trig_addr, prev_addr, exp_taddr;
   logic [31:0] event_count;
   acq_state_e acq_state;

   int cfg [64][11];          // one row of fields per test
   string t_name [64];
   int n_tests, errors, word_mode;
   int period_cur, tot_cur, post_cur, cyc_since_wr, writes_after;
   int trig_count, req_count, events_exp;
   logic gap_valid, in_event, prev_trig, prev_req, loaded;
   longint budget_ns;
   logic [31:0] seed;
   string cur_name;

   triggerer_top #(.SAMPLES_PER_CLK(SPC), .ADDR_W(ADDR_W)) dut0 (
      .clklvds, .arst_n, .samples, .lower, .upper, .pre_len, .post_len, .trig_type,
      .tot, .downsample, .merge, .trigger_live, .ext_trig, .done_ack, .ram_wr, .wr_addr,
      .trig_out, .trig_addr, .event_count, .done_req, .acq_state
   );

   initial begin
      clklvds = 1'b0;
      forever #(CLK_NS / 2) clklvds = ~clklvds;
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223; // lcg step
      return seed;
   endfunction

   // one sample inside the quiet band or beyond a threshold
   function automatic sample_t pick(input int mode);
      logic [31:0] r;
      int v;
      r = next_rand();
      case (mode)
         BELOW:   v = int'(lower) - 1 - int'(r % 32'd50);
         ABOVE:   v = int'(upper) + 1 + int'(r % 32'd50);
         default: v = int'(lower) + 1 + int'(r % 32'(int'(upper) - int'(lower) - 1));
      endcase
      return sample_t'(v);
   endfunction

   task automatic report(input string msg);
      errors++;
      $display("error in test %s: %s", cur_name, msg);
   endtask

   task automatic check_val(input string what, input int exp, input int act);
      assert (exp == act) else begin
         errors++;
         $display("ERROR %s: %s expected %0d actual %0d", cur_name, what, exp, act);
      end
   endtask

   // advance to the next falling edge and drive a fresh word
   task automatic cycle();
      @(negedge clklvds);
      for (int i = 0; i < SPC; i++) samples[i] = pick(word_mode);
   endtask

   // kind 0 state equals target, 1 trig_out high, 2 done_req high, 3 done_req low
   task automatic wait_until(input int kind, input int target, input int limit,
                             input string what);
      int n;
      logic met;
      n = 0;
      met = 1'b0;
      while (!met && n < limit) begin
         cycle();
         n++;
         case (kind)
            0:       met = (int'(acq_state) == target);
            1:       met = trig_out;
            2:       met = done_req;
            default: met = !done_req;
         endcase
      end
      assert (met) else report($sformatf("no %s within %0d cycles", what, limit));
   endtask

   // sampled just after the rising edge where outputs have settled
   always @(posedge clklvds) begin
      #2;
      if (arst_n) begin
         cyc_since_wr++;
         if (ram_wr) begin
            check_val("wr_addr step", (int'(prev_addr) + 1) % (1 << ADDR_W), int'(wr_addr));
            if (gap_valid) check_val("write period", period_cur, cyc_since_wr);
            cyc_since_wr = 0;
            gap_valid = 1'b1;
            if (in_event) writes_after++;
            assert (!done_req) else report("ram_wr pulsed while done_req was high");
         end
         if (acq_state == ST_IDLE || acq_state == ST_HOLD) gap_valid = 1'b0; // not recording
         if (trig_out && !prev_trig) begin
            exp_taddr = prev_addr - ADDR_W'(tot_cur);
            check_val("trig_addr", int'(exp_taddr), int'(trig_addr));
            assert (!done_ack) else report("trig_out rose while done_ack was still high");
            in_event = 1'b1;
            writes_after = 0;
            trig_count++;
         end
         if (done_req && !prev_req) begin
            assert (in_event) else report("done_req rose without a trigger");
            check_val("writes after trigger", post_cur, writes_after);
            check_val("event_count", events_exp + 1, int'(event_count));
            events_exp++;
            in_event = 1'b0;
            req_count++;
         end
         prev_trig = trig_out;
         prev_req  = done_req;
         prev_addr = wr_addr;
      end
   end

   task automatic run_test(input int t);
      int period, lim, trig_before, req_before, ev_before;
      cur_name    = t_name[t];
      period      = (1 << cfg[t][F_DS]) * cfg[t][F_MRG];
      period_cur  = period;
      tot_cur     = cfg[t][F_TOT];
      post_cur    = cfg[t][F_POST];
      trig_before = trig_count;
      req_before  = req_count;
      ev_before   = events_exp;
      lim         = (cfg[t][F_PRE] + cfg[t][F_TOT] + 10) * period + 20;
      cycle();
      lower        = sample_t'(cfg[t][F_LOW]);
      upper        = sample_t'(cfg[t][F_UP]);
      pre_len      = LEN_W'(cfg[t][F_PRE]);
      post_len     = LEN_W'(cfg[t][F_POST]);
      tot          = TOT_W'(cfg[t][F_TOT]);
      downsample   = DS_W'(cfg[t][F_DS]);
      merge        = MERGE_W'(cfg[t][F_MRG]);
      trig_type    = 8'(cfg[t][F_TYPE]);
      trigger_live = 1'b1;
      if (cfg[t][F_TYPE] == 1 || cfg[t][F_TYPE] == 2) begin
         wait_until(0, int'(ST_ARM), lim, "ST_ARM");
         if (cfg[t][F_PAT] == 3) begin
            trig_type    = 8'(TRIG_FALLING); // rewrite while armed
            trigger_live = 1'b0;
         end else if (cfg[t][F_PAT] != 0) begin
            word_mode = (cfg[t][F_PAT] == 1) ? BELOW : ABOVE;
            cycle();
            word_mode = (cfg[t][F_PAT] == 1) ? ABOVE : BELOW;
            repeat ((cfg[t][F_TOT] + 2) * period + 6) cycle();
            word_mode = QUIET;
         end
      end else if (cfg[t][F_TYPE] == 5) begin
         wait_until(0, int'(ST_EXT), lim, "ST_EXT");
         ext_trig = 1'b1;
         repeat (cfg[t][F_EXT]) cycle();
         ext_trig = 1'b0;
      end
      if (cfg[t][F_EXP] != 0) begin
         wait_until(1, 0, lim, "trig_out");
         wait_until(2, 0, (cfg[t][F_POST] + 10) * period + 20, "done_req");
         check_val("trigger count", trig_before + 1, trig_count);
         repeat (3) cycle();
         assert (done_req) else report("done_req dropped before done_ack");
         done_ack = 1'b1;
         wait_until(3, 0, 10, "done_req release");
         repeat (cfg[t][F_PRE] * period + 8) cycle(); // type stays live, an early rearm would fire
         check_val("state while ack high", int'(ST_HOLD), int'(acq_state));
         trig_type    = 8'(TRIG_OFF); // no rearm after this event
         trigger_live = 1'b0;
         done_ack     = 1'b0;
         wait_until(0, int'(ST_IDLE), 10, "ST_IDLE after readout");
      end else begin
         repeat ((cfg[t][F_TOT] + 4) * period + 10) cycle(); // window with no trigger
         check_val("trigger count", trig_before, trig_count);
         check_val("done_req count", req_before, req_count);
         check_val("event_count", ev_before, int'(event_count));
         trig_type    = 8'(TRIG_OFF);
         trigger_live = 1'b0;
         wait_until(0, int'(ST_IDLE), 20, "ST_IDLE after abort");
      end
   endtask

   initial begin
      int fd, nf;
      string line, nm;
      int f [11];
      arst_n = 1'b0;
      trigger_live = 1'b0;
      ext_trig = 1'b0;
      done_ack = 1'b0;
      lower = '0;
      upper = '0;
      pre_len = '0;
      post_len = '0;
      trig_type = '0;
      tot = '0;
      downsample = '0;
      merge = '0;
      for (int i = 0; i < SPC; i++) samples[i] = '0;
      seed = 32'h361f_8c49;
      word_mode = QUIET;
      errors = 0;
      n_tests = 0;
      trig_count = 0;
      req_count = 0;
      events_exp = 0;
      cyc_since_wr = 0;
      writes_after = 0;
      period_cur = 1;
      tot_cur = 0;
      post_cur = 0;
      gap_valid = 1'b0;
      in_event = 1'b0;
      prev_trig = 1'b0;
      prev_req = 1'b0;
      prev_addr = '0;
      loaded = 1'b0;
      cur_name = "setup";
      budget_ns = 40 * CLK_NS; // reset and start up
      fd = $fopen("verif/triggerer_testdata.txt", "r");
      assert (fd != 0) else report("cannot open verif/triggerer_testdata.txt");
      while (fd != 0 && !$feof(fd) && n_tests < 64) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#") begin
            nf = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d", nm, f[0], f[1],
                         f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (nf == 12) begin
               t_name[n_tests] = nm;
               for (int k = 0; k < 11; k++) cfg[n_tests][k] = f[k];
               budget_ns += longint'(f[F_PRE] + f[F_POST] + 50) * (1 << f[F_DS]) *
                            f[F_MRG] * CLK_NS + 200 * CLK_NS;
               n_tests++;
            end
         end
      end
      if (fd != 0) $fclose(fd);
      assert (n_tests > 0) else report("no tests found in the data file");
      loaded = 1'b1;
      repeat (10) @(posedge clklvds);
      @(negedge clklvds);
      arst_n = 1'b1;
      for (int t = 0; t < n_tests; t++) run_test(t);
      repeat (5) cycle();
      $display("tests run: %0d, failed checks: %0d, events: %0d", n_tests, errors, events_exp);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // ends a run that got stuck somewhere
   initial begin
      wait (loaded);
      #(budget_ns);
      $display("watchdog expired after %0d ns in test %s", budget_ns, cur_name);
      $display("tests run: %0d, failed checks: %0d, events: %0d", n_tests, errors, events_exp);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== verif/triggerer_testdata.txt ====
# name type lower upper pre_len post_len tot downsample merge pattern ext_len expect_fire
# type 1 rising 2 falling 4 auto 5 ext, pattern 0 quiet 1 below-then-above 2 mirror 3 type change
auto_basic   4 -300 300   8  12 0 0 1 0  0 1
auto_ds2     4 -300 300   4   6 0 2 3 0  0 1
auto_wrap    4 -300 300 600 500 0 0 1 0  0 1
rise_fire    1 -300 300   6  10 3 1 2 1  0 1
rise_tot0    1 -200 200   5   7 0 0 1 1  0 1
fall_fire    2 -300 300   6  10 3 0 2 2  0 1
fall_ds3     2 -400 250   3   5 2 3 1 2  0 1
rise_quiet   1 -300 300   4   8 2 0 1 0  0 0
fall_quiet   2 -300 300   4   8 2 1 1 0  0 0
ext_long     5 -300 300   5   9 6 0 1 0 10 1
ext_short    5 -300 300   5   9 6 0 1 0  1 0
ext_ds       5 -300 300   3   6 4 1 2 0  8 1
type_change  1 -300 300   5   9 2 0 1 3  0 0
auto_after   4 -300 300   2   4 0 1 1 0  0 1
